// File: hw/memblock_pkg.sv
`default_nettype none

package memblock_pkg;

    // ##########################################################################
    // Data path geometry
    // ##########################################################################

    // Data and address width of the core
    // The alignment logic relies on eight bytes per bus word
    localparam int xlen = 64;

    localparam int byte_bits    = 8;                  // Bits per byte lane
    localparam int word_bytes   = xlen / byte_bits;   // Byte lanes per bus word
    localparam int offset_width = $clog2(word_bytes); // Byte offset inside a bus word

    // ##########################################################################
    // Load size codes
    // ##########################################################################

    // Encoded as log2 of the access size in bytes
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } ls_size_e;

endpackage

`default_nettype wire

// File: hw/agu.sv
`timescale 1ns/1ns
`default_nettype none

module agu (
    input  logic [memblock_pkg::xlen-1:0] src1,
    input  logic [memblock_pkg::xlen-1:0] imm,
    input  memblock_pkg::ls_size_e        ls_size,
    output logic [memblock_pkg::xlen-1:0] ls_address,
    output logic                          misaligned
);
    import memblock_pkg::*;

    logic [offset_width-1:0] align_mask;   // Low address bits that must be zero

    // Effective address, base plus offset
    assign ls_address = src1 + imm;

    // Required alignment follows the access size
    always_comb begin
        case (ls_size)
            size_byte: begin
                align_mask = '0;           // Any byte address is fine
            end
            size_half: begin
                align_mask = 3'b001;
            end
            size_word: begin
                align_mask = 3'b011;
            end
            default: begin
                align_mask = 3'b111;       // Double word
            end
        endcase
    end

    // Any set bit under the mask breaks alignment
    assign misaligned = |(ls_address[offset_width-1:0] & align_mask);

endmodule

`default_nettype wire

// File: hw/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  logic [memblock_pkg::xlen-1:0]         read_data,
    input  logic [memblock_pkg::offset_width-1:0] byte_offset,
    input  memblock_pkg::ls_size_e                ls_size,
    input  logic                                  is_unsigned,
    output logic [memblock_pkg::xlen-1:0]         load_data
);
    import memblock_pkg::*;

    logic [xlen-1:0] shifted;   // Addressed bytes moved down to lane 0
    logic            sign_bit;

    // Move the addressed bytes to the bottom of the word
    assign shifted = read_data >> (byte_offset * byte_bits);

    // ##########################################################################
    // Size select and extension
    // ##########################################################################

    always_comb begin
        sign_bit = 1'b0;
        case (ls_size)
            size_byte: begin
                sign_bit  = shifted[7] & ~is_unsigned;
                load_data = {{(xlen - 8){sign_bit}}, shifted[7:0]};
            end
            size_half: begin
                sign_bit  = shifted[15] & ~is_unsigned;
                load_data = {{(xlen - 16){sign_bit}}, shifted[15:0]};
            end
            size_word: begin
                sign_bit  = shifted[31] & ~is_unsigned;
                load_data = {{(xlen - 32){sign_bit}}, shifted[31:0]};
            end
            default: begin
                // Full double word needs neither shift nor extension
                load_data = read_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/load_control.sv
`timescale 1ns/1ns
`default_nettype none

module load_control #(
    parameter int ROB_IDX_WIDTH = 6,
    parameter int PREG_WIDTH    = 7
) (
    input  logic                                  clock,
    input  logic                                  reset_n,
    // Issue side
    input  logic                                  instr_valid,
    output logic                                  instr_ready,
    input  logic [PREG_WIDTH-1:0]                 prd,
    input  logic                                  is_unsigned,
    input  memblock_pkg::ls_size_e                ls_size,
    input  logic                                  robidx_flag,
    input  logic [ROB_IDX_WIDTH-1:0]              robidx,
    // From the address generator
    input  logic [memblock_pkg::xlen-1:0]         ls_address,
    input  logic                                  misaligned,
    // Data cache bus, read channel
    output logic                                  tbus_index_valid,
    input  logic                                  tbus_index_ready,
    output logic [memblock_pkg::xlen-1:0]         tbus_index,
    input  logic                                  tbus_operation_done,
    // Held entry attributes for the aligner
    output logic [memblock_pkg::offset_width-1:0] byte_offset,
    output memblock_pkg::ls_size_e                held_size,
    output logic                                  held_unsigned,
    // Redirect flush
    input  logic                                  flush_valid,
    input  logic                                  flush_robidx_flag,
    input  logic [ROB_IDX_WIDTH-1:0]              flush_robidx,
    output logic                                  dcache_flush,
    // Writeback
    output logic                                  ldu_out_valid,
    output logic [PREG_WIDTH-1:0]                 ldu_out_prd,
    output logic                                  ldu_out_robidx_flag,
    output logic [ROB_IDX_WIDTH-1:0]              ldu_out_robidx,
    output logic                                  ldu_out_misaligned
);
    import memblock_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_takein,        // Request goes out this cycle
        st_pending,       // Request waits on ready
        st_outstanding,   // Waiting for the done pulse
        st_misaligned     // Completes with the exception flag
    } state_e;

    state_e state;
    state_e state_nxt;

    logic                     req_fire;
    logic                     tbus_fire;
    logic                     arrive_flush;
    logic                     held_flush;

    logic [xlen-1:0]          addr_q;
    logic [PREG_WIDTH-1:0]    prd_q;
    ls_size_e                 size_q;
    logic                     unsigned_q;
    logic                     flag_q;
    logic [ROB_IDX_WIDTH-1:0] idx_q;

    // True when the ROB entry lies behind the flush point
    function automatic logic is_younger(
        input logic                     flag,
        input logic [ROB_IDX_WIDTH-1:0] idx,
        input logic                     fl_flag,
        input logic [ROB_IDX_WIDTH-1:0] fl_idx
    );
        return (flag ^ fl_flag) ^ (fl_idx < idx);
    endfunction

    assign instr_ready = (state == st_idle);
    assign req_fire    = instr_valid & instr_ready;
    assign tbus_fire   = tbus_index_valid & tbus_index_ready;

    // ##########################################################################
    // Flush decisions
    // ##########################################################################

    // Incoming load killed on its accept beat
    assign arrive_flush = flush_valid
                        & is_younger(robidx_flag, robidx, flush_robidx_flag, flush_robidx);

    // Held entry killed, tell the cache to drop its request
    assign held_flush = flush_valid & (state != st_idle)
                      & is_younger(flag_q, idx_q, flush_robidx_flag, flush_robidx);

    assign dcache_flush = held_flush;

    // ##########################################################################
    // Entry capture
    // ##########################################################################

    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q     <= ls_address;
            prd_q      <= prd;
            size_q     <= ls_size;
            unsigned_q <= is_unsigned;
            flag_q     <= robidx_flag;
            idx_q      <= robidx;
        end
    end

    // ##########################################################################
    // Entry state machine
    // ##########################################################################

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_fire && !arrive_flush) begin
                    state_nxt = misaligned ? st_misaligned : st_takein;
                end
            end
            st_takein: begin
                state_nxt = tbus_fire ? st_outstanding : st_pending;
            end
            st_pending: begin
                if (tbus_fire) begin
                    state_nxt = st_outstanding;
                end
            end
            st_outstanding: begin
                if (tbus_operation_done) begin
                    state_nxt = st_idle;   // Writeback this cycle
                end
            end
            st_misaligned: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
        // A flush of the held entry overrides any progress
        if (held_flush) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Bus request, index is the double word holding the access
    assign tbus_index_valid = (state == st_takein) || (state == st_pending);
    assign tbus_index       = {addr_q[xlen-1:offset_width], {offset_width{1'b0}}};

    // Attributes for the aligner
    assign byte_offset   = addr_q[offset_width-1:0];
    assign held_size     = size_q;
    assign held_unsigned = unsigned_q;

    // Writeback, done pulses outside the outstanding state are ignored
    assign ldu_out_valid = (((state == st_outstanding) && tbus_operation_done)
                           || (state == st_misaligned)) && !held_flush;
    assign ldu_out_misaligned  = (state == st_misaligned);
    assign ldu_out_prd         = prd_q;
    assign ldu_out_robidx_flag = flag_q;
    assign ldu_out_robidx      = idx_q;

endmodule

`default_nettype wire

// File: hw/load_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_unit #(
    parameter int ROB_IDX_WIDTH = 6,
    parameter int PREG_WIDTH    = 7
) (
    input  logic                          clock,
    input  logic                          reset_n,
    // Issue
    input  logic                          instr_valid,
    output logic                          instr_ready,
    input  logic [PREG_WIDTH-1:0]         prd,
    input  logic                          is_unsigned,
    input  memblock_pkg::ls_size_e        ls_size,
    input  logic [memblock_pkg::xlen-1:0] src1,
    input  logic [memblock_pkg::xlen-1:0] imm,
    input  logic                          robidx_flag,
    input  logic [ROB_IDX_WIDTH-1:0]      robidx,
    // Data cache bus
    output logic                          tbus_index_valid,
    input  logic                          tbus_index_ready,
    output logic [memblock_pkg::xlen-1:0] tbus_index,
    input  logic [memblock_pkg::xlen-1:0] tbus_read_data,
    input  logic                          tbus_operation_done,
    // Redirect flush
    input  logic                          flush_valid,
    input  logic                          flush_robidx_flag,
    input  logic [ROB_IDX_WIDTH-1:0]      flush_robidx,
    output logic                          dcache_flush,
    // Writeback
    output logic                          ldu_out_valid,
    output logic [PREG_WIDTH-1:0]         ldu_out_prd,
    output logic                          ldu_out_robidx_flag,
    output logic [ROB_IDX_WIDTH-1:0]      ldu_out_robidx,
    output logic [memblock_pkg::xlen-1:0] ldu_out_load_data,
    output logic                          ldu_out_misaligned
);
    import memblock_pkg::*;

    logic [xlen-1:0]         ls_address;
    logic                    misaligned;
    logic [offset_width-1:0] byte_offset;   // Held address low bits
    ls_size_e                held_size;
    logic                    held_unsigned;

    // Address and alignment check on the issue payload
    agu u_agu (
        .src1       (src1),
        .imm        (imm),
        .ls_size    (ls_size),
        .ls_address (ls_address),
        .misaligned (misaligned)
    );

    load_control #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH),
        .PREG_WIDTH    (PREG_WIDTH)
    ) u_load_control (
        .clock               (clock),
        .reset_n             (reset_n),
        .instr_valid         (instr_valid),
        .instr_ready         (instr_ready),
        .prd                 (prd),
        .is_unsigned         (is_unsigned),
        .ls_size             (ls_size),
        .robidx_flag         (robidx_flag),
        .robidx              (robidx),
        .ls_address          (ls_address),
        .misaligned          (misaligned),
        .tbus_index_valid    (tbus_index_valid),
        .tbus_index_ready    (tbus_index_ready),
        .tbus_index          (tbus_index),
        .tbus_operation_done (tbus_operation_done),
        .byte_offset         (byte_offset),
        .held_size           (held_size),
        .held_unsigned       (held_unsigned),
        .flush_valid         (flush_valid),
        .flush_robidx_flag   (flush_robidx_flag),
        .flush_robidx        (flush_robidx),
        .dcache_flush        (dcache_flush),
        .ldu_out_valid       (ldu_out_valid),
        .ldu_out_prd         (ldu_out_prd),
        .ldu_out_robidx_flag (ldu_out_robidx_flag),
        .ldu_out_robidx      (ldu_out_robidx),
        .ldu_out_misaligned  (ldu_out_misaligned)
    );

    // Returned double word goes straight to writeback after alignment
    load_align u_load_align (
        .read_data   (tbus_read_data),
        .byte_offset (byte_offset),
        .ls_size     (held_size),
        .is_unsigned (held_unsigned),
        .load_data   (ldu_out_load_data)
    );

endmodule

`default_nettype wire

// File: tb/load_unit_properties.sv
`timescale 1ns/1ns
`default_nettype none

module load_unit_properties (
    input logic                          clock,
    input logic                          reset_n,
    input logic                          instr_ready,
    input logic                          tbus_index_valid,
    input logic                          tbus_index_ready,
    input logic [memblock_pkg::xlen-1:0] tbus_index,
    input logic                          ldu_out_valid,
    input logic                          dcache_flush
);

    // Request waiting on ready keeps valid and index, unless its entry is flushed
    a_request_held : assert property (
        @(posedge clock) disable iff (!reset_n)
        tbus_index_valid && !tbus_index_ready && !dcache_flush
        |=> tbus_index_valid && $stable(tbus_index)
    ) else $error("bus request changed before the bus took it");

    a_no_issue_during_request : assert property (
        @(posedge clock) disable iff (!reset_n)
        tbus_index_valid |-> !instr_ready
    ) else $error("issue ready while a bus request is open");

    a_writeback_not_idle : assert property (
        @(posedge clock) disable iff (!reset_n)
        !(ldu_out_valid && instr_ready)
    ) else $error("writeback while the unit reports idle");

    a_flush_without_writeback : assert property (
        @(posedge clock) disable iff (!reset_n)
        !(dcache_flush && ldu_out_valid)
    ) else $error("cache cancel and writeback in the same cycle");

endmodule

`default_nettype wire

// File: tb/load_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module load_unit_tb;
    import memblock_pkg::*;

    localparam int rob_w           = 6;
    localparam int preg_w          = 7;
    localparam int num_loads       = 300;
    localparam int max_load_cycles = 20;   // Worst issue gap, ready wait and done delay
    localparam int timeout_cycles  = num_loads * max_load_cycles + 100;

    logic              clock, reset_n;
    logic              instr_valid, instr_ready, is_unsigned, robidx_flag;
    logic [preg_w-1:0] prd, ldu_out_prd;
    ls_size_e          ls_size;
    logic [xlen-1:0]   src1, imm, tbus_index, tbus_read_data, ldu_out_load_data;
    logic [rob_w-1:0]  robidx, flush_robidx, ldu_out_robidx;
    logic              tbus_index_valid, tbus_index_ready, tbus_operation_done;
    logic              flush_valid, flush_robidx_flag, dcache_flush;
    logic              ldu_out_valid, ldu_out_robidx_flag, ldu_out_misaligned;

    int                seed = 89314;
    int                errors, checks, issued, writebacks, flushed, dropped;
    logic [xlen-1:0]   mem [256];

    // Model of the single held entry
    logic              busy, ent_mis, ent_taken, ent_uns, ent_flag;
    logic              hit, exp_wb, exp_req;
    logic [xlen-1:0]   ent_addr;
    ls_size_e          ent_size;
    logic [preg_w-1:0] ent_prd;
    logic [rob_w-1:0]  ent_idx;

    // Bus and issue side state
    int                timer, ready_wait, gap;
    logic              ready_n, done_n, pend;
    logic [xlen-1:0]   bus_word;

    load_unit #(.ROB_IDX_WIDTH(rob_w), .PREG_WIDTH(preg_w)) i_load_unit (.*);

    bind load_unit load_unit_properties i_properties (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // ROB order with a wrap bit, a lap change flips the index compare
    function automatic logic entry_is_younger(input logic flag, input logic [rob_w-1:0] idx,
                                              input logic fl_flag, input logic [rob_w-1:0] fl_idx);
        if (flag == fl_flag) begin
            return idx > fl_idx;
        end else begin
            return idx <= fl_idx;
        end
    endfunction

    // Pick the addressed bytes one by one, then fill the upper bytes
    function automatic logic [xlen-1:0] expect_load(input logic [xlen-1:0] word,
                                                    input logic [2:0] off,
                                                    input ls_size_e size, input logic uns);
        int              nbytes;
        int              i;
        logic [xlen-1:0] val;
        nbytes = 1 << int'(size);
        val    = '0;
        for (i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = word[8*(int'(off) + i) +: 8];
        end
        for (i = nbytes; i < 8; i++) begin
            val[8*i +: 8] = {8{val[8*nbytes-1] & !uns}};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // ##########################################################################
    // Per-cycle stimulus, bus model and reference model
    // ##########################################################################

    task automatic drive_inputs();
        ls_size_e        size_v;
        int              nbytes;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] base;
        if (!pend && issued < num_loads) begin
            if (gap > 0) begin
                gap = gap - 1;
            end else begin
                size_v = ls_size_e'(2'(rand_below(4)));
                nbytes = 1 << int'(size_v);
                addr   = {$random(seed), $random(seed)};
                base   = {$random(seed), $random(seed)};
                if (rand_below(8) != 0) begin
                    addr[2:0] = addr[2:0] & 3'(~(nbytes - 1));   // Mostly aligned
                end
                ls_size     <= size_v;
                src1        <= base;
                imm         <= addr - base;
                is_unsigned <= 1'(rand_below(2));
                prd         <= preg_w'(rand_below(128));
                robidx_flag <= 1'(rand_below(2));
                robidx      <= rob_w'(rand_below(64));
                pend   = 1'b1;
                issued = issued + 1;
                gap    = rand_below(4);
            end
        end
        instr_valid         <= pend;
        flush_valid         <= (rand_below((pend && !busy) ? 4 : 12) == 0);   // More on accept
        flush_robidx_flag   <= 1'(rand_below(2));
        flush_robidx        <= rob_w'(rand_below(64));
        tbus_index_ready    <= ready_n;
        tbus_operation_done <= done_n;
        tbus_read_data      <= done_n ? bus_word : {$random(seed), $random(seed)};
    endtask

    task automatic check_and_advance();
        int nbytes;
        hit     = busy && flush_valid
                  && entry_is_younger(ent_flag, ent_idx, flush_robidx_flag, flush_robidx);
        exp_req = busy && !ent_mis && !ent_taken;
        exp_wb  = busy && !hit && (ent_mis || (ent_taken && tbus_operation_done));
        check_value("instr_ready", instr_ready, !busy);
        check_value("tbus_index_valid", tbus_index_valid, exp_req);
        check_value("dcache_flush", dcache_flush, hit);
        check_value("ldu_out_valid", ldu_out_valid, exp_wb);
        if (exp_req) begin
            check_value("tbus_index", tbus_index, {ent_addr[xlen-1:3], 3'b000});
        end
        if (exp_wb && ldu_out_valid) begin
            check_value("ldu_out_prd", ldu_out_prd, ent_prd);
            check_value("ldu_out_robidx_flag", ldu_out_robidx_flag, ent_flag);
            check_value("ldu_out_robidx", ldu_out_robidx, ent_idx);
            check_value("ldu_out_misaligned", ldu_out_misaligned, ent_mis);
            if (!ent_mis) begin
                check_value("ldu_out_load_data", ldu_out_load_data,
                            expect_load(mem[ent_addr[10:3]], ent_addr[2:0], ent_size, ent_uns));
            end
        end
        // Entry state after the coming edge
        if (busy) begin
            if (hit) begin
                busy    = 1'b0;
                flushed = flushed + 1;
            end else if (exp_wb) begin
                busy       = 1'b0;
                writebacks = writebacks + 1;
            end else if (exp_req && tbus_index_ready) begin
                ent_taken = 1'b1;
            end
        end else if (instr_valid) begin
            pend = 1'b0;
            if (flush_valid
                && entry_is_younger(robidx_flag, robidx, flush_robidx_flag, flush_robidx)) begin
                dropped = dropped + 1;                // Killed on its accept beat
            end else begin
                busy      = 1'b1;
                ent_taken = 1'b0;
                ent_addr  = src1 + imm;
                ent_size  = ls_size;
                ent_uns   = is_unsigned;
                ent_prd   = prd;
                ent_flag  = robidx_flag;
                ent_idx   = robidx;
                nbytes    = 1 << int'(ls_size);
                ent_mis   = (int'(ent_addr[2:0]) % nbytes) != 0;
            end
        end
    endtask

    task automatic bus_step();
        done_n = 1'b0;
        if (dcache_flush) begin
            timer   = 0;                              // Cancelled read never completes
            ready_n = 1'b0;
        end else if (tbus_index_valid && tbus_index_ready) begin
            bus_word   = mem[tbus_index[10:3]];
            timer      = 1 + rand_below(6);
            ready_n    = 1'b0;
            ready_wait = rand_below(4);
        end else begin
            if (timer > 0) begin
                timer  = timer - 1;
                done_n = (timer == 0);
            end
            if (!tbus_index_valid) begin
                ready_n = (rand_below(3) == 0);       // Sometimes ready ahead of the request
            end else if (ready_wait == 0) begin
                ready_n = 1'b1;
            end else begin
                ready_wait = ready_wait - 1;
            end
        end
    endtask

    initial begin : stimulus
        int i;
        reset_n = 1'b0;
        ls_size = size_byte;
        {instr_valid, is_unsigned, robidx_flag, prd, robidx} = '0;
        {src1, imm, tbus_read_data, tbus_index_ready, tbus_operation_done} = '0;
        {flush_valid, flush_robidx_flag, flush_robidx} = '0;
        {busy, pend, ready_n, done_n} = '0;
        for (i = 0; i < 256; i++) begin
            mem[i] = {$random(seed), $random(seed)};
        end
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value("instr_ready", instr_ready, 1'b1);
        check_value("tbus_index_valid", tbus_index_valid, 1'b0);
        check_value("ldu_out_valid", ldu_out_valid, 1'b0);
        check_value("dcache_flush", dcache_flush, 1'b0);
        while (issued < num_loads || pend || busy) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            check_and_advance();
            bus_step();
        end
        $display("loads %0d, writebacks %0d, flushed %0d, dropped %0d, checks %0d, errors %0d",
                 issued, writebacks, flushed, dropped, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout: the loads did not finish within %0d cycles", timeout_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/memblock_pkg.sv
hw/agu.sv
hw/load_align.sv
hw/load_control.sv
hw/load_unit.sv
tb/load_unit_properties.sv
tb/load_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module load_unit_tb --Mdir obj_dir -o load_unit_sim

status=0
./obj_dir/load_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "tests failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished clean"
